/* hdl/valu_settings.svh */
`ifndef VALU_SETTINGS_SVH
`define VALU_SETTINGS_SVH

// number of vector lanes
`define VALU_LANES 4

// lane word width
`define VALU_WIDTH 32

// opcode width
`define VALU_OPW 5

`endif

/* hdl/valu_pkg.sv */
`include "valu_settings.svh"

package valu_pkg;

    // opcodes in issue order
    typedef enum logic [`VALU_OPW-1:0] {
        Fadd,
        Fsub,
        Fmult,
        Vadd,
        Vsub,
        Vmult,
        Vdot,
        Vdota,
        Vindx,
        Vreduce,
        Vsplat,
        Vswizzle,
        Vsadd,
        Vssub,
        Vsmult,
        Vcompsel,
        Vmax,
        Vmin
    } valuOp_e;

    typedef enum logic [1:0] {
        LADD,
        LSUB,
        LMUL,
        LPASS    // returns a
    } laneOp_e;

    // how the last stage builds vout and rout
    typedef enum logic [3:0] {
        RK_SCALAR,
        RK_VECTOR,
        RK_SUM,
        RK_SUMACC,
        RK_INDEX,
        RK_SPLAT,
        RK_SWIZZLE,
        RK_COMPSEL,
        RK_MAX,
        RK_MIN,
        RK_NONE
    } resultKind_e;

    typedef logic [`VALU_LANES-1:0][`VALU_WIDTH-1:0] laneVec_t;

    typedef struct packed {
        resultKind_e kind;
        logic [2*`VALU_LANES-1:0] imm;
        logic [`VALU_WIDTH-1:0] r1;
        logic [`VALU_WIDTH-1:0] r2;
        laneVec_t v1;
        laneVec_t v2;
        laneVec_t res;
        logic [`VALU_LANES-1:0] gt;
    } stageA_t;

    typedef struct packed {
        resultKind_e kind;
        logic [2*`VALU_LANES-1:0] imm;
        logic [`VALU_WIDTH-1:0] r1;
        logic [`VALU_WIDTH-1:0] r2;
        laneVec_t v1;
        laneVec_t res;
        logic [`VALU_LANES-1:0] gt;
        logic [`VALU_WIDTH-1:0] partLo;    // lanes 0 and 1
        logic [`VALU_WIDTH-1:0] partHi;    // lanes 2 and 3
    } stageB_t;

endpackage

/* hdl/laneAlu.sv */
`include "valu_settings.svh"

module laneAlu (
    input  logic [`VALU_WIDTH-1:0] a,
    input  logic [`VALU_WIDTH-1:0] b,
    input  valu_pkg::laneOp_e      laneOp,
    output logic [`VALU_WIDTH-1:0] result,
    output logic                   gt
);

    // integer arithmetic wraps, the product keeps its low word
    always_comb begin
        case (laneOp)
            valu_pkg::LADD: result = a + b;
            valu_pkg::LSUB: result = a - b;
            valu_pkg::LMUL: result = a * b;
            default:        result = a;
        endcase
    end

    // signed compare, equal lanes are not greater
    assign gt = $signed(a) > $signed(b);

endmodule

/* hdl/opDecoder.sv */
`include "valu_settings.svh"

module opDecoder (
    input  logic [`VALU_OPW-1:0]    op,
    output valu_pkg::laneOp_e       laneOps [`VALU_LANES],
    output logic                    selScalarA,
    output logic                    selScalarB,
    output logic                    selZeroB,
    output valu_pkg::resultKind_e   kind
);

    valu_pkg::laneOp_e laneFn;    // function shared by the active lanes

    always_comb begin
        laneFn     = valu_pkg::LPASS;
        selScalarA = 1'b0;
        selScalarB = 1'b0;
        selZeroB   = 1'b0;
        kind       = valu_pkg::RK_NONE;
        case (op)
            // ####################
            // scalar ops run on lane 0 only
            valu_pkg::Fadd: begin
                laneFn     = valu_pkg::LADD;
                selScalarA = 1'b1;
                kind       = valu_pkg::RK_SCALAR;
            end
            valu_pkg::Fsub: begin
                laneFn     = valu_pkg::LSUB;
                selScalarA = 1'b1;
                kind       = valu_pkg::RK_SCALAR;
            end
            valu_pkg::Fmult: begin
                laneFn     = valu_pkg::LMUL;
                selScalarA = 1'b1;
                kind       = valu_pkg::RK_SCALAR;
            end
            // ####################
            valu_pkg::Vadd:  begin laneFn = valu_pkg::LADD; kind = valu_pkg::RK_VECTOR; end
            valu_pkg::Vsub:  begin laneFn = valu_pkg::LSUB; kind = valu_pkg::RK_VECTOR; end
            valu_pkg::Vmult: begin laneFn = valu_pkg::LMUL; kind = valu_pkg::RK_VECTOR; end
            valu_pkg::Vdot:  begin laneFn = valu_pkg::LMUL; kind = valu_pkg::RK_SUM; end
            valu_pkg::Vdota: begin laneFn = valu_pkg::LMUL; kind = valu_pkg::RK_SUMACC; end
            valu_pkg::Vindx:    kind = valu_pkg::RK_INDEX;
            valu_pkg::Vreduce: begin
                selZeroB = 1'b1;    // lanes hand v1 to the tree
                kind     = valu_pkg::RK_SUM;
            end
            valu_pkg::Vsplat:   kind = valu_pkg::RK_SPLAT;
            valu_pkg::Vswizzle: kind = valu_pkg::RK_SWIZZLE;
            // ####################
            // scalar r1 against every v1 lane
            valu_pkg::Vsadd: begin
                laneFn     = valu_pkg::LADD;
                selScalarB = 1'b1;
                kind       = valu_pkg::RK_VECTOR;
            end
            valu_pkg::Vssub: begin
                laneFn     = valu_pkg::LSUB;
                selScalarB = 1'b1;
                kind       = valu_pkg::RK_VECTOR;
            end
            valu_pkg::Vsmult: begin
                laneFn     = valu_pkg::LMUL;
                selScalarB = 1'b1;
                kind       = valu_pkg::RK_VECTOR;
            end
            valu_pkg::Vcompsel: kind = valu_pkg::RK_COMPSEL;    // only the gt flags matter
            valu_pkg::Vmax:     kind = valu_pkg::RK_MAX;
            valu_pkg::Vmin:     kind = valu_pkg::RK_MIN;
            default: ;
        endcase
    end

    // upper lanes idle during scalar ops
    assign laneOps[0] = laneFn;
    for (genvar k = 1; k < `VALU_LANES; k++) begin : gLaneOp
        assign laneOps[k] = selScalarA ? valu_pkg::LPASS : laneFn;
    end

endmodule

/* hdl/pipeStage.sv */
module pipeStage #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     inValid,
    output logic     inReady,
    input  payload_t inData,
    output logic     outValid,
    input  logic     outReady,
    output payload_t outData
);

    logic full;

    // a full stage still takes a new item when its own is leaving
    assign inReady  = !full || outReady;
    assign outValid = full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full    <= 1'b0;
            outData <= '0;
        end else begin
            if (inValid && inReady) begin
                full    <= 1'b1;
                outData <= inData;
            end else if (full && outReady) begin
                full <= 1'b0;    // drained with nothing behind it
            end
        end
    end

endmodule

/* hdl/reduceTree.sv */
`include "valu_settings.svh"

module reduceTree (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   aValid,
    output logic                   aReady,
    input  valu_pkg::stageA_t      aData,
    output logic                   bValid,
    input  logic                   bReady,
    output logic [`VALU_WIDTH-1:0] sum,
    output valu_pkg::stageB_t      bData
);

    valu_pkg::stageB_t bIn;

    // first level of the sum, before the register
    always_comb begin
        bIn.kind   = aData.kind;
        bIn.imm    = aData.imm;
        bIn.r1     = aData.r1;
        bIn.r2     = aData.r2;
        bIn.v1     = aData.v1;
        bIn.gt     = aData.gt;
        bIn.partLo = aData.res[0] + aData.res[1];
        bIn.partHi = aData.res[2] + aData.res[3];
        // max and min lanes only passed v1, their result slot carries v2 onward
        if (aData.kind == valu_pkg::RK_MAX || aData.kind == valu_pkg::RK_MIN) begin
            bIn.res = aData.v2;
        end else begin
            bIn.res = aData.res;
        end
    end

    pipeStage #(.payload_t(valu_pkg::stageB_t)) uStageB (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (aValid),
        .inReady  (aReady),
        .inData   (bIn),
        .outValid (bValid),
        .outReady (bReady),
        .outData  (bData)
    );

    assign sum = bData.partLo + bData.partHi;    // second level

endmodule

/* hdl/vectorAlu.sv */
`include "valu_settings.svh"

module vectorAlu (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       inValid,
    output logic                       inReady,
    input  logic [`VALU_OPW-1:0]       op,
    input  logic [2*`VALU_LANES-1:0]   imm,
    input  valu_pkg::laneVec_t         v1,
    input  valu_pkg::laneVec_t         v2,
    input  logic [`VALU_WIDTH-1:0]     r1,
    input  logic [`VALU_WIDTH-1:0]     r2,
    output logic                       outValid,
    input  logic                       outReady,
    output valu_pkg::laneVec_t         vout,
    output logic [`VALU_WIDTH-1:0]     rout
);

    localparam int SELW = $clog2(`VALU_LANES);

    typedef struct packed {
        valu_pkg::laneVec_t     vout;
        logic [`VALU_WIDTH-1:0] rout;
    } result_t;

    valu_pkg::laneOp_e      laneOps [`VALU_LANES];
    logic                   selScalarA;
    logic                   selScalarB;
    logic                   selZeroB;
    valu_pkg::resultKind_e  kind;
    valu_pkg::laneVec_t     laneA;
    valu_pkg::laneVec_t     laneB;
    valu_pkg::laneVec_t     laneRes;
    logic [`VALU_LANES-1:0] laneGt;

    valu_pkg::stageA_t      aIn;
    valu_pkg::stageA_t      aData;
    logic                   aValid;
    logic                   aReady;
    valu_pkg::stageB_t      bData;
    logic                   bValid;
    logic                   bReady;
    logic [`VALU_WIDTH-1:0] treeSum;
    result_t                resIn;
    result_t                resOut;

    // ####################
    // decode and lanes

    opDecoder uDecoder (
        .op         (op),
        .laneOps    (laneOps),
        .selScalarA (selScalarA),
        .selScalarB (selScalarB),
        .selZeroB   (selZeroB),
        .kind       (kind)
    );

    for (genvar k = 0; k < `VALU_LANES; k++) begin : gLane
        if (k == 0) begin : gScalar
            // lane 0 doubles as the scalar unit
            assign laneA[k] = selScalarA ? r1 : v1[k];
            assign laneB[k] = selScalarA ? r2 :
                              selZeroB   ? '0 :
                              selScalarB ? r1 : v2[k];
        end else begin : gVector
            assign laneA[k] = v1[k];
            assign laneB[k] = selZeroB   ? '0 :
                              selScalarB ? r1 : v2[k];
        end

        laneAlu uLane (
            .a      (laneA[k]),
            .b      (laneB[k]),
            .laneOp (laneOps[k]),
            .result (laneRes[k]),
            .gt     (laneGt[k])
        );
    end

    always_comb begin
        aIn.kind = kind;
        aIn.imm  = imm;
        aIn.r1   = r1;
        aIn.r2   = r2;
        aIn.v1   = v1;
        aIn.v2   = v2;
        aIn.res  = laneRes;
        aIn.gt   = laneGt;
    end

    pipeStage #(.payload_t(valu_pkg::stageA_t)) uStageA (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (aIn),
        .outValid (aValid),
        .outReady (aReady),
        .outData  (aData)
    );

    // ####################
    // summation, then result assembly

    reduceTree uTree (
        .clk    (clk),
        .rst_n  (rst_n),
        .aValid (aValid),
        .aReady (aReady),
        .aData  (aData),
        .bValid (bValid),
        .bReady (bReady),
        .sum    (treeSum),
        .bData  (bData)
    );

    always_comb begin
        resIn = '0;    // fields a kind leaves alone stay zero
        case (bData.kind)
            valu_pkg::RK_SCALAR: resIn.rout = bData.res[0];
            valu_pkg::RK_VECTOR: resIn.vout = bData.res;
            valu_pkg::RK_SUM:    resIn.rout = treeSum;
            valu_pkg::RK_SUMACC: resIn.rout = treeSum + bData.r1;
            valu_pkg::RK_INDEX:  resIn.rout = bData.v1[bData.imm[SELW-1:0]];
            valu_pkg::RK_SPLAT: begin
                for (int k = 0; k < `VALU_LANES; k++) begin
                    resIn.vout[k] = bData.r1;
                end
            end
            valu_pkg::RK_SWIZZLE: begin
                for (int k = 0; k < `VALU_LANES; k++) begin
                    resIn.vout[k] = bData.v1[bData.imm[SELW*k +: SELW]];
                end
            end
            valu_pkg::RK_COMPSEL: begin
                for (int k = 0; k < `VALU_LANES; k++) begin
                    resIn.vout[k] = bData.gt[k] ? bData.r1 : bData.r2;
                end
            end
            valu_pkg::RK_MAX: begin
                // res holds v2 for max and min
                for (int k = 0; k < `VALU_LANES; k++) begin
                    resIn.vout[k] = bData.gt[k] ? bData.v1[k] : bData.res[k];
                end
            end
            valu_pkg::RK_MIN: begin
                for (int k = 0; k < `VALU_LANES; k++) begin
                    resIn.vout[k] = bData.gt[k] ? bData.res[k] : bData.v1[k];
                end
            end
            default: ;
        endcase
    end

    pipeStage #(.payload_t(result_t)) uStageOut (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (bValid),
        .inReady  (bReady),
        .inData   (resIn),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (resOut)
    );

    assign vout = resOut.vout;    // straight from the output register
    assign rout = resOut.rout;

endmodule

/* bench/vectorAlu_sva.sv */
`include "valu_settings.svh"

module vectorAlu_sva (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   inReady,
    input logic                   aValid,
    input logic                   bValid,
    input logic                   outValid,
    input logic                   outReady,
    input valu_pkg::laneVec_t     vout,
    input logic [`VALU_WIDTH-1:0] rout
);

    timeunit 1ns;
    timeprecision 100ps;

    // no result may be offered while reset is held
    quietInReset: assert property (@(posedge clk) !rst_n |-> !outValid)
        else $error("outValid high during reset");

    // an offered result stays put until the sink takes it
    holdResult: assert property (@(posedge clk) disable iff (!rst_n)
        outValid && !outReady |=> outValid && $stable(vout) && $stable(rout))
        else $error("result changed or vanished while stalled");

    // some stage is free or the sink is draining, so a request must be taken
    readyWhenRoom: assert property (@(posedge clk) disable iff (!rst_n)
        (!aValid || !bValid || !outValid || outReady) |-> inReady)
        else $error("inReady low although the pipeline has room");

endmodule

/* bench/vectorAlu_tb.sv */
`include "valu_settings.svh"

module vectorAlu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int LANES = `VALU_LANES;
    localparam int VW = LANES * `VALU_WIDTH;
    localparam int NREQ = 300;
    localparam int STIM_LIMIT = 20 * NREQ;
    localparam int DRAIN_LIMIT = 100;

    logic clk;
    logic rst_n;
    logic inValid;
    logic inReady;
    logic [`VALU_OPW-1:0] op;
    logic [2*LANES-1:0] imm;
    valu_pkg::laneVec_t v1;
    valu_pkg::laneVec_t v2;
    logic [`VALU_WIDTH-1:0] r1;
    logic [`VALU_WIDTH-1:0] r2;
    logic outValid;
    logic outReady;
    valu_pkg::laneVec_t vout;
    logic [`VALU_WIDTH-1:0] rout;

    logic [31:0] rngState = 32'd6;
    int errors = 0;
    longint cycle = 0;
    longint lastStall = 0;    // last edge where the sink held off
    int accCount = 0;
    int takeCount = 0;
    valu_pkg::laneVec_t expVout [$];
    logic [`VALU_WIDTH-1:0] expRout [$];
    longint accCycle [$];

    vectorAlu dut (.*);

    bind vectorAlu vectorAlu_sva uSva (
        .clk(clk), .rst_n(rst_n), .inReady(inReady),
        .aValid(aValid), .bValid(bValid), .outValid(outValid),
        .outReady(outReady), .vout(vout), .rout(rout)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        rngState ^= rngState << 13;
        rngState ^= rngState >> 17;
        rngState ^= rngState << 5;
        return rngState;
    endfunction

    // small values now and then, so signs and equal lanes show up
    function automatic logic [31:0] randWord();
        if (nextRand() % 3 == 0) return nextRand() % 32 - 16;
        return nextRand();
    endfunction

    task automatic checkValue(input logic [VW-1:0] got, input logic [VW-1:0] want,
                              input string what);
        if (got !== want) begin
            errors++;
            $display("FAIL %0t: %s got %0h expected %0h", $time, what, got, want);
        end
    endtask

    // #################### reference model
    function automatic void modelOp(input logic [`VALU_OPW-1:0] opc, input logic [7:0] im,
                                    input valu_pkg::laneVec_t a, input valu_pkg::laneVec_t b,
                                    input logic [31:0] s1, input logic [31:0] s2,
                                    output valu_pkg::laneVec_t ev, output logic [31:0] er);
        ev = '0;
        er = '0;
        case (opc)
            valu_pkg::Fadd:  er = s1 + s2;
            valu_pkg::Fsub:  er = s1 - s2;
            valu_pkg::Fmult: er = s1 * s2;
            valu_pkg::Vadd:  for (int k = 0; k < LANES; k++) ev[k] = a[k] + b[k];
            valu_pkg::Vsub:  for (int k = 0; k < LANES; k++) ev[k] = a[k] - b[k];
            valu_pkg::Vmult: for (int k = 0; k < LANES; k++) ev[k] = a[k] * b[k];
            valu_pkg::Vdot:  for (int k = 0; k < LANES; k++) er = er + a[k] * b[k];
            valu_pkg::Vdota: begin
                er = s1;    // accumulator seeds the dot product
                for (int k = 0; k < LANES; k++) er = er + a[k] * b[k];
            end
            valu_pkg::Vindx:    er = a[im[1:0]];
            valu_pkg::Vreduce:  for (int k = 0; k < LANES; k++) er = er + a[k];
            valu_pkg::Vsplat:   for (int k = 0; k < LANES; k++) ev[k] = s1;
            valu_pkg::Vswizzle: for (int k = 0; k < LANES; k++) ev[k] = a[im[2*k +: 2]];
            valu_pkg::Vsadd:  for (int k = 0; k < LANES; k++) ev[k] = a[k] + s1;
            valu_pkg::Vssub:  for (int k = 0; k < LANES; k++) ev[k] = a[k] - s1;
            valu_pkg::Vsmult: for (int k = 0; k < LANES; k++) ev[k] = a[k] * s1;
            valu_pkg::Vcompsel: for (int k = 0; k < LANES; k++)
                ev[k] = ($signed(a[k]) > $signed(b[k])) ? s1 : s2;
            valu_pkg::Vmax: for (int k = 0; k < LANES; k++)
                ev[k] = ($signed(a[k]) > $signed(b[k])) ? a[k] : b[k];
            valu_pkg::Vmin: for (int k = 0; k < LANES; k++)
                ev[k] = ($signed(a[k]) > $signed(b[k])) ? b[k] : a[k];
            default: ;    // unused opcodes stay all zero
        endcase
    endfunction

    task automatic driveRequest();
        valu_pkg::laneVec_t a;
        valu_pkg::laneVec_t b;
        for (int k = 0; k < LANES; k++) begin
            a[k] = randWord();
            b[k] = (nextRand() % 4 == 0) ? a[k] : randWord();
        end
        op      <= nextRand() % 24;
        imm     <= nextRand();
        v1      <= a;
        v2      <= b;
        r1      <= randWord();
        r2      <= randWord();
        inValid <= 1'b1;
    endtask

    // #################### scoreboard
    always @(posedge clk) begin : monitor
        valu_pkg::laneVec_t ev;
        logic [31:0] er;
        longint latency;
        cycle <= cycle + 1;
        if (!outReady) lastStall <= cycle;
        if (!rst_n) begin
            checkValue(outValid, 0, "outValid during reset");
        end else begin
            checkValue(accCount - takeCount <= 3, 1, "at most three items in flight");
            if (outValid && outReady) begin
                if (expRout.size() == 0) begin
                    errors++;
                    $display("a result was taken with no request pending");
                end else begin
                    checkValue(vout, expVout.pop_front(), "vout");
                    checkValue(rout, expRout.pop_front(), "rout");
                    latency = cycle - accCycle[0];
                    checkValue(latency >= 3, 1, "latency at least three cycles");
                    if (lastStall <= accCycle[0]) checkValue(latency, 3, "unstalled latency");
                    void'(accCycle.pop_front());
                end
                takeCount <= takeCount + 1;
            end
            if (inValid && inReady) begin
                modelOp(op, imm, v1, v2, r1, r2, ev, er);
                expVout.push_back(ev);
                expRout.push_back(er);
                accCycle.push_back(cycle);
                accCount <= accCount + 1;
            end
        end
    end

    initial begin : stimulus
        int sent;
        int guard;
        rst_n <= 1'b0;
        inValid = 1'b0;
        op = '0;
        imm = '0;
        v1 = '0;
        v2 = '0;
        r1 = '0;
        r2 = '0;
        outReady = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        sent = 0;
        guard = 0;
        while (sent < NREQ && guard < STIM_LIMIT) begin
            @(posedge clk);
            guard++;
            if (inValid && inReady) sent++;
            if (!inValid || inReady) begin    // a stalled request must hold
                if (sent < NREQ && nextRand() % 4 != 0) driveRequest();
                else inValid <= 1'b0;
            end
            // a long stall window lets all three stages fill
            if (guard >= 100 && guard < 140) outReady <= 1'b0;
            else outReady <= (nextRand() % 4 != 0);
        end
        if (sent < NREQ) begin
            errors++;
            $display("stimulus timed out with %0d of %0d requests accepted", sent, NREQ);
        end

        guard = 0;
        while (takeCount < sent && guard < DRAIN_LIMIT) begin
            @(posedge clk);
            guard++;
            outReady <= 1'b1;
        end
        if (takeCount < sent) begin
            errors++;
            $display("drain timed out with %0d results still missing", sent - takeCount);
        end
        checkValue(expRout.size(), 0, "results left in the model queue");

        $display("%0d errors, %0d requests accepted, %0d results taken",
                 errors, accCount, takeCount);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+hdl
hdl/valu_pkg.sv
hdl/laneAlu.sv
hdl/opDecoder.sv
hdl/pipeStage.sv
hdl/reduceTree.sv
hdl/vectorAlu.sv
bench/vectorAlu_sva.sv
bench/vectorAlu_tb.sv

/* Bender.yml */
package:
  name: vector_alu

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/valu_pkg.sv
      - hdl/laneAlu.sv
      - hdl/opDecoder.sv
      - hdl/pipeStage.sv
      - hdl/reduceTree.sv
      - hdl/vectorAlu.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/vectorAlu_sva.sv
      - bench/vectorAlu_tb.sv
